/* dcls_consts.svh */
`ifndef DCLS_CONSTS_SVH
`define DCLS_CONSTS_SVH

// AHB bus widths
`define DCLS_ADDR_W      32
`define DCLS_DATA_W      32
`define DCLS_HTRANS_W    2
`define DCLS_HSIZE_W     3

// Custom AHB protection
`define DCLS_PARITY_W    6    // Request parity
`define DCLS_CHECKSUM_W  7    // Data checksum

// AHB transfer type IDLE
`define DCLS_HTRANS_IDLE 2'b00

// Replicas of each response line
`define DCLS_TMR_REPS    3

`endif

/* dcls_pkg.sv */
`default_nettype none

`include "dcls_consts.svh"

package dcls_pkg;

    typedef logic [`DCLS_ADDR_W-1:0]     addr_t;
    typedef logic [`DCLS_DATA_W-1:0]     data_t;
    typedef logic [`DCLS_PARITY_W-1:0]   parity_t;
    typedef logic [`DCLS_CHECKSUM_W-1:0] checksum_t;
    typedef logic [`DCLS_HTRANS_W-1:0]   htrans_t;
    typedef logic [`DCLS_HSIZE_W-1:0]    hsize_t;

    // Instruction bus request of one core
    typedef struct packed {
        htrans_t htrans;
        addr_t   haddr;
        parity_t hparity;
    } ibus_req_t;

    // Data bus request of one core
    typedef struct packed {
        htrans_t   htrans;
        addr_t     haddr;
        hsize_t    hsize;
        logic      hwrite;
        parity_t   hparity;
        data_t     hwdata;
        checksum_t hwchecksum;
    } dbus_req_t;

    typedef struct packed {
        logic hready;   // End of transfer
        logic hresp;    // Error response
    } bus_rsp_t;

    typedef bus_rsp_t [`DCLS_TMR_REPS-1:0] bus_rsp_tmr_t;

    typedef struct packed {
        data_t     hrdata;
        checksum_t hrchecksum;
    } bus_rd_t;

    // Everything a core gets from the system
    typedef struct packed {
        bus_rsp_t ibus_rsp;
        bus_rsp_t dbus_rsp;
        bus_rd_t  ibus_rd;
        bus_rd_t  dbus_rd;
        logic     meip;     // External interrupt
        logic     mtip;     // Timer interrupt
    } core_in_t;

endpackage

`default_nettype wire

/* tmr_vote.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcls_consts.svh"

module tmr_vote import dcls_pkg::*; (
    input  bus_rsp_tmr_t ibus_rsp_tmr_i,
    input  bus_rsp_tmr_t dbus_rsp_tmr_i,
    output bus_rsp_t     ibus_rsp_o,
    output bus_rsp_t     dbus_rsp_o
);

    // Bitwise two of three
    function automatic bus_rsp_t vote3(input bus_rsp_tmr_t rep);
        return bus_rsp_t'((rep[0] & rep[1]) | (rep[0] & rep[2]) | (rep[1] & rep[2]));
    endfunction

    always_comb begin
        ibus_rsp_o = vote3(ibus_rsp_tmr_i);
        dbus_rsp_o = vote3(dbus_rsp_tmr_i);

        // Warn about an upset replica that the vote masks
        for (int r = 0; r < `DCLS_TMR_REPS; r++) begin
            assert (ibus_rsp_tmr_i[r] == ibus_rsp_o)
                else $warning("ibus response replica %0d outvoted", r);
            assert (dbus_rsp_tmr_i[r] == dbus_rsp_o)
                else $warning("dbus response replica %0d outvoted", r);
        end
    end

endmodule

`default_nettype wire

/* trail_input_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module trail_input_delay import dcls_pkg::*; (
    input  logic     s_clk_i,
    input  logic     arst_n_i,

    input  bus_rsp_t ibus_rsp_i,    // Voted responses
    input  bus_rsp_t dbus_rsp_i,
    input  bus_rd_t  ibus_rd_i,     // Read data and checksum
    input  bus_rd_t  dbus_rd_i,
    input  logic     int_meip_i,
    input  logic     int_mtip_i,

    output core_in_t lead_in_o,     // Leading core in the same cycle
    output core_in_t trail_in_o     // Trailing core one cycle later
);

    // Leading core sees the system directly
    always_comb begin
        lead_in_o.ibus_rsp = ibus_rsp_i;
        lead_in_o.dbus_rsp = dbus_rsp_i;
        lead_in_o.ibus_rd  = ibus_rd_i;
        lead_in_o.dbus_rd  = dbus_rd_i;
        lead_in_o.meip     = int_meip_i;
        lead_in_o.mtip     = int_mtip_i;
    end

    // Trailing core runs one cycle behind, so its inputs do too
    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            trail_in_o <= '0;
        end else begin
            trail_in_o <= lead_in_o;
        end
    end

    property p_trail_follows_lead;
        @(posedge s_clk_i) disable iff (!arst_n_i)
            $past(arst_n_i) |-> (trail_in_o == $past(lead_in_o));
    endproperty

    a_trail_follows_lead: assert property (p_trail_follows_lead)
        else $error("trailing core inputs are not the delayed leading inputs");

endmodule

`default_nettype wire

/* ibus_lockstep_cmp.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcls_consts.svh"

module ibus_lockstep_cmp import dcls_pkg::*; (
    input  logic      s_clk_i,
    input  logic      arst_n_i,
    input  ibus_req_t lead_i,
    input  ibus_req_t trail_i,
    output logic      err_o     // Instruction bus discrepancy
);

    htrans_t lead_htrans_q1;
    htrans_t lead_htrans_q2;
    htrans_t trail_htrans_q;
    addr_t   lead_addr_q1;
    addr_t   lead_addr_q2;
    addr_t   trail_addr_q;
    parity_t lead_par_q1;
    parity_t lead_par_q2;
    parity_t trail_par_q;

    // Transfer type through two leading stages and one trailing stage
    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lead_htrans_q1 <= `DCLS_HTRANS_IDLE;
            lead_htrans_q2 <= `DCLS_HTRANS_IDLE;
            trail_htrans_q <= `DCLS_HTRANS_IDLE;
        end else begin
            lead_htrans_q1 <= lead_i.htrans;
            lead_htrans_q2 <= lead_htrans_q1;   // Extra stage to line up with trailing
            trail_htrans_q <= trail_i.htrans;
        end
    end

    always_ff @(posedge s_clk_i) begin
        lead_addr_q1 <= lead_i.haddr;
        lead_addr_q2 <= lead_addr_q1;
        trail_addr_q <= trail_i.haddr;
        lead_par_q1  <= lead_i.hparity;
        lead_par_q2  <= lead_par_q1;
        trail_par_q  <= trail_i.hparity;
    end

    always_comb begin
        err_o = 1'b0;
        if (lead_htrans_q2 != trail_htrans_q) begin
            err_o = 1'b1;
        end else if (trail_htrans_q != `DCLS_HTRANS_IDLE) begin
            // Address phase only matters for an active transfer
            err_o = (lead_addr_q2 != trail_addr_q) || (lead_par_q2 != trail_par_q);
        end
    end

    a_no_err_after_reset: assert property (@(posedge s_clk_i) $rose(arst_n_i) |-> !err_o)
        else $error("ibus discrepancy right after reset release");

endmodule

`default_nettype wire

/* dbus_lockstep_cmp.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcls_consts.svh"

module dbus_lockstep_cmp import dcls_pkg::*; (
    input  logic      s_clk_i,
    input  logic      arst_n_i,
    input  dbus_req_t lead_i,
    input  dbus_req_t trail_i,
    output logic      err_o     // Data bus discrepancy
);

    htrans_t   lead_htrans_q1;
    htrans_t   lead_htrans_q2;
    htrans_t   trail_htrans_q;
    data_t     lead_wdata_q1;
    data_t     lead_wdata_q2;
    data_t     trail_wdata_q;
    checksum_t lead_wchk_q1;
    checksum_t lead_wchk_q2;
    checksum_t trail_wchk_q;
    addr_t     lead_addr_q1;
    addr_t     lead_addr_q2;
    addr_t     trail_addr_q;
    hsize_t    lead_size_q1;
    hsize_t    lead_size_q2;
    hsize_t    trail_size_q;
    logic      lead_write_q1;
    logic      lead_write_q2;
    logic      trail_write_q;
    parity_t   lead_par_q1;
    parity_t   lead_par_q2;
    parity_t   trail_par_q;

    // Transfer type and write data
    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lead_htrans_q1 <= `DCLS_HTRANS_IDLE;
            lead_htrans_q2 <= `DCLS_HTRANS_IDLE;
            trail_htrans_q <= `DCLS_HTRANS_IDLE;
            lead_wdata_q1  <= '0;
            lead_wdata_q2  <= '0;
            trail_wdata_q  <= '0;
            lead_wchk_q1   <= '0;
            lead_wchk_q2   <= '0;
            trail_wchk_q   <= '0;
        end else begin
            lead_htrans_q1 <= lead_i.htrans;
            lead_htrans_q2 <= lead_htrans_q1;
            trail_htrans_q <= trail_i.htrans;
            lead_wdata_q1  <= lead_i.hwdata;
            lead_wdata_q2  <= lead_wdata_q1;
            trail_wdata_q  <= trail_i.hwdata;
            lead_wchk_q1   <= lead_i.hwchecksum;
            lead_wchk_q2   <= lead_wchk_q1;
            trail_wchk_q   <= trail_i.hwchecksum;
        end
    end

    always_ff @(posedge s_clk_i) begin
        lead_addr_q1  <= lead_i.haddr;
        lead_addr_q2  <= lead_addr_q1;
        trail_addr_q  <= trail_i.haddr;
        lead_size_q1  <= lead_i.hsize;
        lead_size_q2  <= lead_size_q1;
        trail_size_q  <= trail_i.hsize;
        lead_write_q1 <= lead_i.hwrite;
        lead_write_q2 <= lead_write_q1;
        trail_write_q <= trail_i.hwrite;
        lead_par_q1   <= lead_i.hparity;
        lead_par_q2   <= lead_par_q1;
        trail_par_q   <= trail_i.hparity;
    end

    always_comb begin
        err_o = 1'b0;
        if (lead_htrans_q2 != trail_htrans_q) begin
            err_o = 1'b1;
        end else if (trail_htrans_q != `DCLS_HTRANS_IDLE) begin
            err_o = (lead_addr_q2 != trail_addr_q) || (lead_size_q2 != trail_size_q) ||
                    (lead_write_q2 != trail_write_q) || (lead_par_q2 != trail_par_q);
        end
        // Data phase is not tracked so any write data difference counts
        if ((lead_wdata_q2 != trail_wdata_q) || (lead_wchk_q2 != trail_wchk_q)) begin
            err_o = 1'b1;
        end
    end

    a_no_err_after_reset: assert property (@(posedge s_clk_i) $rose(arst_n_i) |-> !err_o)
        else $error("dbus discrepancy right after reset release");

endmodule

`default_nettype wire

/* dcls_lockstep.sv */
`timescale 1ns/1ps
`default_nettype none

module dcls_lockstep import dcls_pkg::*; (
    input  logic         s_clk_i,
    input  logic         arst_n_i,

    // System side responses with triplicated handshake lines
    input  bus_rsp_tmr_t ibus_rsp_tmr_i,
    input  bus_rsp_tmr_t dbus_rsp_tmr_i,
    input  bus_rd_t      ibus_rd_i,
    input  bus_rd_t      dbus_rd_i,
    input  logic         int_meip_i,
    input  logic         int_mtip_i,

    // Requests from both cores
    input  ibus_req_t    lead_ibus_i,
    input  ibus_req_t    trail_ibus_i,
    input  dbus_req_t    lead_dbus_i,
    input  dbus_req_t    trail_dbus_i,

    output ibus_req_t    ibus_o,        // To the system
    output dbus_req_t    dbus_o,
    output core_in_t     lead_in_o,     // To the leading core
    output core_in_t     trail_in_o,    // To the trailing core
    output logic         unrec_err_o    // Cores have diverged
);

    bus_rsp_t ibus_rsp;
    bus_rsp_t dbus_rsp;
    logic     ibus_err;
    logic     dbus_err;

    // Leading core owns the system buses
    assign ibus_o = lead_ibus_i;
    assign dbus_o = lead_dbus_i;

    assign unrec_err_o = ibus_err || dbus_err;

    tmr_vote u_tmr_vote (
        .ibus_rsp_tmr_i (ibus_rsp_tmr_i),
        .dbus_rsp_tmr_i (dbus_rsp_tmr_i),
        .ibus_rsp_o     (ibus_rsp),
        .dbus_rsp_o     (dbus_rsp)
    );

    trail_input_delay u_trail_input_delay (
        .s_clk_i    (s_clk_i),
        .arst_n_i   (arst_n_i),
        .ibus_rsp_i (ibus_rsp),
        .dbus_rsp_i (dbus_rsp),
        .ibus_rd_i  (ibus_rd_i),
        .dbus_rd_i  (dbus_rd_i),
        .int_meip_i (int_meip_i),
        .int_mtip_i (int_mtip_i),
        .lead_in_o  (lead_in_o),
        .trail_in_o (trail_in_o)
    );

    ibus_lockstep_cmp u_ibus_cmp (
        .s_clk_i  (s_clk_i),
        .arst_n_i (arst_n_i),
        .lead_i   (lead_ibus_i),
        .trail_i  (trail_ibus_i),
        .err_o    (ibus_err)
    );

    dbus_lockstep_cmp u_dbus_cmp (
        .s_clk_i  (s_clk_i),
        .arst_n_i (arst_n_i),
        .lead_i   (lead_dbus_i),
        .trail_i  (trail_dbus_i),
        .err_o    (dbus_err)
    );

endmodule

`default_nettype wire

/* tb_dcls_lockstep.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcls_consts.svh"

module tb_dcls_lockstep import dcls_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    // Reset and the five tests in order
    localparam int TEST_CYCLES = 2 + 1 + 8 + 50 + 8 + 20 + 26;
    localparam int MARGIN_NS   = 200;

    logic         s_clk_i = 1'b0;
    logic         arst_n_i;
    bus_rsp_tmr_t ibus_rsp_tmr_i;
    bus_rsp_tmr_t dbus_rsp_tmr_i;
    bus_rd_t      ibus_rd_i;
    bus_rd_t      dbus_rd_i;
    logic         int_meip_i;
    logic         int_mtip_i;
    ibus_req_t    lead_ibus_i;
    ibus_req_t    trail_ibus_i;
    dbus_req_t    lead_dbus_i;
    dbus_req_t    trail_dbus_i;
    ibus_req_t    ibus_o;
    dbus_req_t    dbus_o;
    core_in_t     lead_in_o;
    core_in_t     trail_in_o;
    logic         unrec_err_o;

    int           seed;
    // Request history with h0 the newest
    ibus_req_t    lead_i_h0, lead_i_h1, lead_i_h2, trail_i_h0, trail_i_h1;
    dbus_req_t    lead_d_h0, lead_d_h1, lead_d_h2, trail_d_h0, trail_d_h1;
    core_in_t     exp_lead_prev;
    // System side values for the next cycle
    bus_rsp_tmr_t sys_ibus_tmr, sys_dbus_tmr;
    bus_rd_t      sys_ibus_rd, sys_dbus_rd;
    logic         sys_meip, sys_mtip;

    dcls_lockstep DUT (.*);

    always #(CLK_PERIOD / 2) s_clk_i = ~s_clk_i;

    function automatic htrans_t rand_htrans();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0];
    endfunction

    function automatic ibus_req_t rand_ibus(input htrans_t tr);
        ibus_req_t   req;
        logic [31:0] r;
        r           = $random(seed);
        req.htrans  = tr;
        req.haddr   = $random(seed);
        req.hparity = r[5:0];
        return req;
    endfunction

    function automatic dbus_req_t rand_dbus(input htrans_t tr);
        dbus_req_t   req;
        logic [31:0] r;
        r              = $random(seed);
        req.htrans     = tr;
        req.haddr      = $random(seed);
        req.hsize      = r[2:0];
        req.hwrite     = r[3];
        req.hparity    = r[9:4];
        req.hwdata     = $random(seed);
        req.hwchecksum = r[16:10];
        return req;
    endfunction

    // High when at least two replicas of a line are high
    function automatic bus_rsp_t majority(input bus_rsp_tmr_t reps);
        bus_rsp_t v;
        int       n_ready;
        int       n_resp;
        n_ready = 0;
        n_resp  = 0;
        for (int i = 0; i < `DCLS_TMR_REPS; i++) begin
            if (reps[i].hready) n_ready++;
            if (reps[i].hresp) n_resp++;
        end
        v.hready = (n_ready >= 2);
        v.hresp  = (n_resp >= 2);
        return v;
    endfunction

    function automatic core_in_t expected_core_in();
        core_in_t c;
        c.ibus_rsp = majority(sys_ibus_tmr);
        c.dbus_rsp = majority(sys_dbus_tmr);
        c.ibus_rd  = sys_ibus_rd;
        c.dbus_rd  = sys_dbus_rd;
        c.meip     = sys_meip;
        c.mtip     = sys_mtip;
        return c;
    endfunction

    function automatic logic ibus_diverged(input ibus_req_t l, input ibus_req_t t);
        if (l.htrans != t.htrans) return 1'b1;
        if (t.htrans == `DCLS_HTRANS_IDLE) return 1'b0;   // Idle address phase is ignored
        return (l.haddr != t.haddr) || (l.hparity != t.hparity);
    endfunction

    function automatic logic dbus_diverged(input dbus_req_t l, input dbus_req_t t);
        if ((l.hwdata != t.hwdata) || (l.hwchecksum != t.hwchecksum)) return 1'b1;
        if (l.htrans != t.htrans) return 1'b1;
        if (t.htrans == `DCLS_HTRANS_IDLE) return 1'b0;
        return (l.haddr != t.haddr) || (l.hsize != t.hsize) ||
               (l.hwrite != t.hwrite) || (l.hparity != t.hparity);
    endfunction

    task automatic check_ibus(input ibus_req_t got, input ibus_req_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s got %h expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_dbus(input dbus_req_t got, input dbus_req_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s got %h expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_core_in(input core_in_t got, input core_in_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s got %h expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s got %b expected %b", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    // Trailing core repeats the previous leading request xor the corruption
    task automatic run_cycle(input ibus_req_t li, input dbus_req_t ld,
                             input ibus_req_t ix, input dbus_req_t dx);
        ibus_req_t ti;
        dbus_req_t td;
        core_in_t  exp_lead;
        ti = lead_i_h0 ^ ix;
        td = lead_d_h0 ^ dx;
        @(posedge s_clk_i);
        lead_ibus_i    <= li;
        trail_ibus_i   <= ti;
        lead_dbus_i    <= ld;
        trail_dbus_i   <= td;
        ibus_rsp_tmr_i <= sys_ibus_tmr;
        dbus_rsp_tmr_i <= sys_dbus_tmr;
        ibus_rd_i      <= sys_ibus_rd;
        dbus_rd_i      <= sys_dbus_rd;
        int_meip_i     <= sys_meip;
        int_mtip_i     <= sys_mtip;
        @(negedge s_clk_i);
        lead_i_h2  = lead_i_h1;
        lead_i_h1  = lead_i_h0;
        lead_i_h0  = li;
        trail_i_h1 = trail_i_h0;
        trail_i_h0 = ti;
        lead_d_h2  = lead_d_h1;
        lead_d_h1  = lead_d_h0;
        lead_d_h0  = ld;
        trail_d_h1 = trail_d_h0;
        trail_d_h0 = td;
        exp_lead   = expected_core_in();
        check_ibus(ibus_o, li, "ibus pass-through");
        check_dbus(dbus_o, ld, "dbus pass-through");
        check_core_in(lead_in_o, exp_lead, "leading core inputs");
        check_core_in(trail_in_o, exp_lead_prev, "trailing core inputs");
        // Leading request two cycles old against trailing one cycle old
        check_err(unrec_err_o, ibus_diverged(lead_i_h2, trail_i_h1) ||
                  dbus_diverged(lead_d_h2, trail_d_h1), "lockstep error flag");
        exp_lead_prev = exp_lead;
    endtask

    task automatic randomize_system();
        logic [31:0] r;
        r                      = $random(seed);
        sys_ibus_tmr           = {3{r[1:0]}};   // Replicas agree
        sys_dbus_tmr           = {3{r[3:2]}};
        sys_meip               = r[4];
        sys_mtip               = r[5];
        sys_ibus_rd.hrdata     = $random(seed);
        sys_ibus_rd.hrchecksum = r[12:6];
        sys_dbus_rd.hrdata     = $random(seed);
        sys_dbus_rd.hrchecksum = r[19:13];
    endtask

    // Corrupt the trailing copy of one transfer and look two edges later
    task automatic corrupt_and_check(input htrans_t itr, input htrans_t dtr, input ibus_req_t ix,
                                     input dbus_req_t dx, input logic exp_err, input string what);
        run_cycle(rand_ibus(itr), rand_dbus(dtr), '0, '0);
        run_cycle(rand_ibus(rand_htrans()), rand_dbus(rand_htrans()), ix, dx);
        run_cycle(rand_ibus(rand_htrans()), rand_dbus(rand_htrans()), '0, '0);
        check_err(unrec_err_o, exp_err, what);
        run_cycle(rand_ibus(rand_htrans()), rand_dbus(rand_htrans()), '0, '0);
        check_err(unrec_err_o, 1'b0, {what, " cleared"});
    endtask

    task automatic reset_and_passthrough();
        repeat (2) @(posedge s_clk_i);
        arst_n_i <= 1'b1;
        @(negedge s_clk_i);
        check_err(unrec_err_o, 1'b0, "error flag after reset");
        check_core_in(trail_in_o, '0, "trailing core inputs after reset");
        repeat (8) run_cycle(rand_ibus(rand_htrans()), rand_dbus(rand_htrans()), '0, '0);
    endtask

    task automatic clean_lockstep();
        repeat (50) begin
            run_cycle(rand_ibus(rand_htrans()), rand_dbus(rand_htrans()), '0, '0);
            check_err(unrec_err_o, 1'b0, "error flag in clean lockstep");
        end
    endtask

    task automatic ibus_mismatch();
        ibus_req_t ix;
        ix       = '0;
        ix.haddr = 32'h0000_0040;
        corrupt_and_check(2'b10, `DCLS_HTRANS_IDLE, ix, '0, 1'b1, "ibus haddr on active transfer");
        corrupt_and_check(`DCLS_HTRANS_IDLE, `DCLS_HTRANS_IDLE, ix, '0, 1'b0,
                          "ibus haddr on idle transfer");
    endtask

    task automatic dbus_rules();
        dbus_req_t size_x;
        dbus_req_t wdata_x;
        dbus_req_t trans_x;
        size_x         = '0;
        size_x.hsize   = 3'b010;
        wdata_x        = '0;
        wdata_x.hwdata = 32'h8000_0001;
        trans_x        = '0;
        trans_x.htrans = 2'b01;
        corrupt_and_check(`DCLS_HTRANS_IDLE, 2'b10, '0, size_x, 1'b1, "dbus hsize on active");
        corrupt_and_check(`DCLS_HTRANS_IDLE, `DCLS_HTRANS_IDLE, '0, size_x, 1'b0,
                          "dbus hsize on idle");
        corrupt_and_check(`DCLS_HTRANS_IDLE, `DCLS_HTRANS_IDLE, '0, wdata_x, 1'b1,
                          "dbus hwdata on idle");
        corrupt_and_check(`DCLS_HTRANS_IDLE, `DCLS_HTRANS_IDLE, '0, trans_x, 1'b1,
                          "dbus htrans from idle");
        corrupt_and_check(`DCLS_HTRANS_IDLE, 2'b11, '0, trans_x, 1'b1, "dbus htrans from active");
    endtask

    task automatic vote_and_delay();
        core_in_t exp;
        for (int r = 0; r < `DCLS_TMR_REPS; r++) begin
            for (int line = 0; line < 2; line++) begin
                randomize_system();
                sys_ibus_tmr = {3{2'b10}};   // Ready without error
                sys_dbus_tmr = {3{2'b01}};   // Not ready with error
                if (line == 0) begin
                    sys_ibus_tmr[r].hready = 1'b0;
                    sys_dbus_tmr[r].hready = 1'b1;
                end else begin
                    sys_ibus_tmr[r].hresp = 1'b1;
                    sys_dbus_tmr[r].hresp = 1'b0;
                end
                run_cycle(rand_ibus(rand_htrans()), rand_dbus(rand_htrans()), '0, '0);
                exp                 = expected_core_in();
                exp.ibus_rsp.hready = 1'b1;
                exp.ibus_rsp.hresp  = 1'b0;
                exp.dbus_rsp.hready = 1'b0;
                exp.dbus_rsp.hresp  = 1'b1;
                check_core_in(lead_in_o, exp, "voted responses with one upset replica");
            end
        end
        repeat (20) begin
            randomize_system();
            run_cycle(rand_ibus(rand_htrans()), rand_dbus(rand_htrans()), '0, '0);
        end
    endtask

    initial begin
        seed           = 32'hb7c8_c05e;
        arst_n_i       = 1'b0;
        ibus_rsp_tmr_i = '0;
        dbus_rsp_tmr_i = '0;
        ibus_rd_i      = '0;
        dbus_rd_i      = '0;
        int_meip_i     = 1'b0;
        int_mtip_i     = 1'b0;
        lead_ibus_i    = '0;
        trail_ibus_i   = '0;
        lead_dbus_i    = '0;
        trail_dbus_i   = '0;
        {lead_i_h0, lead_i_h1, lead_i_h2, trail_i_h0, trail_i_h1} = '0;
        {lead_d_h0, lead_d_h1, lead_d_h2, trail_d_h0, trail_d_h1} = '0;
        exp_lead_prev  = '0;
        {sys_ibus_tmr, sys_dbus_tmr, sys_ibus_rd, sys_dbus_rd, sys_meip, sys_mtip} = '0;

        reset_and_passthrough();
        clean_lockstep();
        ibus_mismatch();
        dbus_rules();
        vote_and_delay();

        $display("test passed");
        $finish;
    end

    // Watchdog
    initial begin
        #(TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("Timeout: the tests did not finish within %0d ns",
                 TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* dcls_lockstep.f */
+incdir+.
dcls_pkg.sv
tmr_vote.sv
trail_input_delay.sv
ibus_lockstep_cmp.sv
dbus_lockstep_cmp.sv
dcls_lockstep.sv
tb_dcls_lockstep.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the lockstep supervisor testbench with Verilator
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f dcls_lockstep.f \
    --top-module tb_dcls_lockstep > build.log 2>&1 &&
{ ./obj_dir/Vtb_dcls_lockstep > sim.log 2>&1 || true; } &&
grep -qx "test passed" sim.log &&
echo "Simulation OK, see sim.log" ||
{
    echo "Simulation FAILED, see build.log and sim.log"
    exit 1
}
